// ==== hawk_pkg.sv ====
package hawk_pkg;

    // bus and field widths
    localparam int unsigned ADDR_W     = 64;
    localparam int unsigned LINE_BYTES = 64;
    localparam int unsigned DATA_W     = 512;
    localparam int unsigned STRB_W     = DATA_W / 8;
    localparam int unsigned PTR_W      = 48;
    localparam int unsigned MD_W       = 400;
    localparam int unsigned LINE_CNT_W = 7;     // counts up to a full 64-line page
    localparam int unsigned FILL_W     = 16;
    localparam int unsigned FILL_REP   = DATA_W / FILL_W;

    // the metadata line is md plus two pointers, padded with zeros at the top
    localparam int unsigned MD_PAD_W = DATA_W - MD_W - 2 * PTR_W;

    localparam logic [ADDR_W-1:0] LINE_STEP = ADDR_W'(LINE_BYTES);

    // lines written per page kind
    localparam logic [LINE_CNT_W-1:0] CPAGE_LINES = 7'd17;
    localparam logic [LINE_CNT_W-1:0] DPAGE_LINES = 7'd64;
    localparam logic [LINE_CNT_W-1:0] MIG_LINES   = 7'd17;

    // fill words, repeated over the whole line
    localparam logic [FILL_W-1:0] CPAGE_FILL = 16'h1234;
    localparam logic [FILL_W-1:0] DPAGE_FILL = 16'hF0F0;
    localparam logic [FILL_W-1:0] MIG_FILL   = 16'h5A5A;

    // metadata only covers 62 bytes, top two are left untouched
    localparam logic [STRB_W-1:0] MD_STRB = {{2{1'b0}}, {(STRB_W - 2){1'b1}}};

    typedef enum logic [1:0] {
        CMD_COMP,
        CMD_DCMP,
        CMD_MIG_COPY,
        CMD_MIG_MD
    } cmd_kind_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LINE_ADDR,
        ST_LINE_DATA,
        ST_MD_ADDR,
        ST_MD_DATA,
        ST_DONE
    } wr_state_e;

    typedef struct packed {
        logic              comp_decomp;       // 1 means compress
        logic [ADDR_W-1:0] cpage_byte_start;
        logic [PTR_W-1:0]  iway_ptr;
        logic [PTR_W-1:0]  nxtway_ptr;
        logic [MD_W-1:0]   zspg_md;
    } page_pkt_t;

    typedef struct packed {
        logic             migrate;
        logic             zspg_update;
        logic [PTR_W-1:0] src_cpage_ptr;
        logic [PTR_W-1:0] dst_cpage_ptr;
        logic [MD_W-1:0]  md;
    } mig_pkt_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } wr_beat_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wr_beat_w_t;

    // both packets are kept side by side, kind tells which one is live
    typedef struct packed {
        cmd_kind_e kind;
        page_pkt_t page;
        mig_pkt_t  mig;
    } wr_cmd_t;

endpackage

// ==== hawk_wr_cmd_latch.sv ====
module hawk_wr_cmd_latch (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                trigger,
    input  hawk_pkg::page_pkt_t page_pkt,
    input  logic                mig_req,
    input  hawk_pkg::mig_pkt_t  mig_pkt,
    input  logic                cmd_take,
    output logic                cmd_valid,
    output hawk_pkg::wr_cmd_t   cmd
);

    logic                pending_q;
    logic                accept;
    hawk_pkg::cmd_kind_e kind_d;
    hawk_pkg::wr_cmd_t   cmd_q;

    // a migrate request with no flag set carries no work
    assign accept = !pending_q &&
                    (trigger || (mig_req && (mig_pkt.migrate || mig_pkt.zspg_update)));

    // trigger wins over mig_req, and migrate wins over zspg_update
    always_comb begin
        if (trigger) begin
            kind_d = page_pkt.comp_decomp ? hawk_pkg::CMD_COMP : hawk_pkg::CMD_DCMP;
        end else if (mig_pkt.migrate) begin
            kind_d = hawk_pkg::CMD_MIG_COPY;
        end else begin
            kind_d = hawk_pkg::CMD_MIG_MD;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (cmd_take) begin
            pending_q <= 1'b0;          // a strobe in this cycle is dropped, latch is still full
        end else if (accept) begin
            pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_q.kind <= kind_d;
            if (trigger) begin
                cmd_q.page <= page_pkt;
            end else begin
                cmd_q.mig <= mig_pkt;
            end
        end
    end

    assign cmd_valid = pending_q;
    assign cmd       = cmd_q;

endmodule

// ==== hawk_cmpdcmp_wr_mngr.sv ====
module hawk_cmpdcmp_wr_mngr (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  cmd_valid,
    input  hawk_pkg::wr_cmd_t     cmd,
    output logic                  cmd_take,
    output logic                  aw_push,
    output hawk_pkg::wr_beat_aw_t aw_beat,
    input  logic                  aw_busy,
    output logic                  w_push,
    output hawk_pkg::wr_beat_w_t  w_beat,
    input  logic                  w_busy,
    output logic                  cmpdcmp_done,
    output logic                  compact_done
);

    hawk_pkg::wr_state_e state_q, state_d;
    hawk_pkg::wr_cmd_t   cmd_q;

    logic [hawk_pkg::LINE_CNT_W-1:0] line_cnt_q, line_cnt_d;
    logic [hawk_pkg::ADDR_W-1:0]     addr_q, addr_d;
    logic                            drain_q, drain_d;   // last beat pushed, waiting for idle

    logic [hawk_pkg::LINE_CNT_W-1:0] num_lines;
    logic [hawk_pkg::FILL_W-1:0]     fill_word;
    logic [hawk_pkg::ADDR_W-1:0]     md_addr;
    logic [hawk_pkg::DATA_W-1:0]     md_data;
    logic [hawk_pkg::ADDR_W-1:0]     start_addr;
    logic                            is_page_op;
    logic                            last_line;

    // base of the fill lines, taken from the command before it is captured
    always_comb begin
        if (cmd.kind == hawk_pkg::CMD_COMP || cmd.kind == hawk_pkg::CMD_DCMP) begin
            start_addr = cmd.page.cpage_byte_start;
        end else begin
            start_addr = {{(hawk_pkg::ADDR_W - hawk_pkg::PTR_W){1'b0}}, cmd.mig.dst_cpage_ptr};
        end
    end

    assign is_page_op = (cmd_q.kind == hawk_pkg::CMD_COMP) || (cmd_q.kind == hawk_pkg::CMD_DCMP);

    // per-kind line count, fill and metadata line
    always_comb begin
        num_lines = hawk_pkg::MIG_LINES;
        fill_word = hawk_pkg::MIG_FILL;
        md_addr   = {{(hawk_pkg::ADDR_W - hawk_pkg::PTR_W){1'b0}}, cmd_q.mig.dst_cpage_ptr};
        md_data   = {{hawk_pkg::MD_PAD_W{1'b0}}, cmd_q.mig.md,
                     cmd_q.mig.src_cpage_ptr, cmd_q.mig.dst_cpage_ptr};
        if (is_page_op) begin
            md_addr = {{(hawk_pkg::ADDR_W - hawk_pkg::PTR_W){1'b0}}, cmd_q.page.iway_ptr};
            md_data = {{hawk_pkg::MD_PAD_W{1'b0}}, cmd_q.page.zspg_md,
                       cmd_q.page.nxtway_ptr, cmd_q.page.iway_ptr};
        end
        case (cmd_q.kind)
            hawk_pkg::CMD_COMP: begin
                num_lines = hawk_pkg::CPAGE_LINES;
                fill_word = hawk_pkg::CPAGE_FILL;
            end
            hawk_pkg::CMD_DCMP: begin
                num_lines = hawk_pkg::DPAGE_LINES;
                fill_word = hawk_pkg::DPAGE_FILL;
            end
            default: ;                  // both migrate kinds keep the migrate values
        endcase
    end

    assign last_line = (line_cnt_q == num_lines - 1'b1);

    always_comb begin
        state_d      = state_q;
        line_cnt_d   = line_cnt_q;
        addr_d       = addr_q;
        drain_d      = drain_q;
        cmd_take     = 1'b0;
        aw_push      = 1'b0;
        w_push       = 1'b0;
        aw_beat.addr = addr_q;
        w_beat.data  = {hawk_pkg::FILL_REP{fill_word}};
        w_beat.strb  = '1;

        unique case (state_q)
            hawk_pkg::ST_IDLE: begin
                if (cmd_valid) begin
                    cmd_take   = 1'b1;
                    line_cnt_d = '0;
                    drain_d    = 1'b0;
                    addr_d     = start_addr;
                    // metadata update skips the fill lines entirely
                    if (cmd.kind == hawk_pkg::CMD_MIG_MD) begin
                        state_d = hawk_pkg::ST_MD_ADDR;
                    end else begin
                        state_d = hawk_pkg::ST_LINE_ADDR;
                    end
                end
            end
            hawk_pkg::ST_LINE_ADDR: begin
                if (!aw_busy) begin
                    aw_push = 1'b1;
                    state_d = hawk_pkg::ST_LINE_DATA;
                end
            end
            hawk_pkg::ST_LINE_DATA: begin
                if (drain_q) begin
                    if (!aw_busy && !w_busy) state_d = hawk_pkg::ST_DONE;
                end else if (!w_busy) begin
                    w_push     = 1'b1;
                    line_cnt_d = line_cnt_q + 1'b1;
                    addr_d     = addr_q + hawk_pkg::LINE_STEP;
                    if (!last_line) begin
                        state_d = hawk_pkg::ST_LINE_ADDR;
                    end else if (cmd_q.kind != hawk_pkg::CMD_MIG_COPY) begin
                        state_d = hawk_pkg::ST_MD_ADDR;
                    end else begin
                        drain_d = 1'b1;     // migrate copy has no metadata line
                    end
                end
            end
            hawk_pkg::ST_MD_ADDR: begin
                aw_beat.addr = md_addr;
                if (!aw_busy) begin
                    aw_push = 1'b1;
                    state_d = hawk_pkg::ST_MD_DATA;
                end
            end
            hawk_pkg::ST_MD_DATA: begin
                w_beat.data = md_data;
                w_beat.strb = hawk_pkg::MD_STRB;
                if (drain_q) begin
                    if (!aw_busy && !w_busy) state_d = hawk_pkg::ST_DONE;
                end else if (!w_busy) begin
                    w_push  = 1'b1;
                    drain_d = 1'b1;
                end
            end
            hawk_pkg::ST_DONE: begin
                state_d = hawk_pkg::ST_IDLE;
            end
            default: state_d = hawk_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= hawk_pkg::ST_IDLE;
            line_cnt_q <= '0;
            drain_q    <= 1'b0;
        end else begin
            state_q    <= state_d;
            line_cnt_q <= line_cnt_d;
            drain_q    <= drain_d;
        end
    end

    // command copy and beat address only matter once a command is taken
    always_ff @(posedge clk_i) begin
        if (cmd_take) cmd_q <= cmd;
        addr_q <= addr_d;
    end

    assign cmpdcmp_done = (state_q == hawk_pkg::ST_DONE) && is_page_op;
    assign compact_done = (state_q == hawk_pkg::ST_DONE) && !is_page_op;

endmodule

// ==== hawk_wr_chan_reg.sv ====
module hawk_wr_chan_reg (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  aw_push,
    input  hawk_pkg::wr_beat_aw_t aw_beat,
    output logic                  aw_busy,
    input  logic                  w_push,
    input  hawk_pkg::wr_beat_w_t  w_beat,
    output logic                  w_busy,
    output logic                  awvalid,
    output hawk_pkg::wr_beat_aw_t aw,
    input  logic                  awready,
    output logic                  wvalid,
    output hawk_pkg::wr_beat_w_t  w,
    input  logic                  wready
);

    logic                  aw_valid_q;
    logic                  w_valid_q;
    hawk_pkg::wr_beat_aw_t aw_q;
    hawk_pkg::wr_beat_w_t  w_q;

    // a slot can take a new beat in the cycle its current one is accepted
    assign aw_busy = aw_valid_q && !awready;
    assign w_busy  = w_valid_q && !wready;

    // address slot
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            aw_valid_q <= 1'b0;
        end else if (aw_push) begin
            aw_valid_q <= 1'b1;
        end else if (awready) begin
            aw_valid_q <= 1'b0;     // handshake done or slot already empty
        end
    end

    // data slot, same rule as the address slot
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            w_valid_q <= 1'b0;
        end else if (w_push) begin
            w_valid_q <= 1'b1;
        end else if (wready) begin
            w_valid_q <= 1'b0;
        end
    end

    // beats are held untouched until the next push
    always_ff @(posedge clk_i) begin
        if (aw_push) aw_q <= aw_beat;
        if (w_push) w_q <= w_beat;
    end

    assign awvalid = aw_valid_q;
    assign aw      = aw_q;
    assign wvalid  = w_valid_q;
    assign w       = w_q;

endmodule

// ==== hawk_wr_top.sv ====
module hawk_wr_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  trigger,
    input  hawk_pkg::page_pkt_t   page_pkt,
    input  logic                  mig_req,
    input  hawk_pkg::mig_pkt_t    mig_pkt,
    output logic                  awvalid,
    output hawk_pkg::wr_beat_aw_t aw,
    input  logic                  awready,
    output logic                  wvalid,
    output hawk_pkg::wr_beat_w_t  w,
    input  logic                  wready,
    output logic                  cmpdcmp_done,
    output logic                  compact_done
);

    logic                  cmd_valid;
    logic                  cmd_take;
    hawk_pkg::wr_cmd_t     cmd;
    logic                  aw_push;
    logic                  aw_busy;
    logic                  w_push;
    logic                  w_busy;
    hawk_pkg::wr_beat_aw_t aw_beat;
    hawk_pkg::wr_beat_w_t  w_beat;

    hawk_wr_cmd_latch u_cmd_latch (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .trigger   (trigger),
        .page_pkt  (page_pkt),
        .mig_req   (mig_req),
        .mig_pkt   (mig_pkt),
        .cmd_take  (cmd_take),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    hawk_cmpdcmp_wr_mngr u_mngr (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_take     (cmd_take),
        .aw_push      (aw_push),
        .aw_beat      (aw_beat),
        .aw_busy      (aw_busy),
        .w_push       (w_push),
        .w_beat       (w_beat),
        .w_busy       (w_busy),
        .cmpdcmp_done (cmpdcmp_done),
        .compact_done (compact_done)
    );

    hawk_wr_chan_reg u_chan_reg (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .aw_push (aw_push),
        .aw_beat (aw_beat),
        .aw_busy (aw_busy),
        .w_push  (w_push),
        .w_beat  (w_beat),
        .w_busy  (w_busy),
        .awvalid (awvalid),
        .aw      (aw),
        .awready (awready),
        .wvalid  (wvalid),
        .w       (w),
        .wready  (wready)
    );

endmodule

// ==== hawk_wr_sva.sv ====
module hawk_wr_sva (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  awvalid,
    input hawk_pkg::wr_beat_aw_t aw,
    input logic                  awready,
    input logic                  wvalid,
    input hawk_pkg::wr_beat_w_t  w,
    input logic                  wready,
    input logic                  cmpdcmp_done,
    input logic                  compact_done
);

    int unsigned err_cnt = 0;   // number of failed assertions in this instance

    // a beat that is not taken must come back unchanged
    aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            err_cnt++;
            $error("aw beat changed or dropped before awready");
        end

    w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin
            err_cnt++;
            $error("w beat changed or dropped before wready");
        end

    cmp_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmpdcmp_done |=> !cmpdcmp_done)
        else begin
            err_cnt++;
            $error("cmpdcmp_done high for more than one cycle");
        end

    mig_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        compact_done |=> !compact_done)
        else begin
            err_cnt++;
            $error("compact_done high for more than one cycle");
        end

    done_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(cmpdcmp_done && compact_done))
        else begin
            err_cnt++;
            $error("both done outputs high together");
        end

endmodule

bind hawk_wr_chan_reg hawk_wr_sva u_chan_sva (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .awvalid      (awvalid),
    .aw           (aw),
    .awready      (awready),
    .wvalid       (wvalid),
    .w            (w),
    .wready       (wready),
    .cmpdcmp_done (1'b0),
    .compact_done (1'b0)
);

bind hawk_cmpdcmp_wr_mngr hawk_wr_sva u_mngr_sva (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .awvalid      (1'b0),
    .aw           ('0),
    .awready      (1'b1),
    .wvalid       (1'b0),
    .w            ('0),
    .wready       (1'b1),
    .cmpdcmp_done (cmpdcmp_done),
    .compact_done (compact_done)
);

// ==== tb_hawk_wr.sv ====
module tb_hawk_wr;

    localparam int unsigned SEED        = 13969;
    localparam int unsigned NUM_RAND    = 50;
    localparam int unsigned NUM_TESTS   = NUM_RAND + 6;
    localparam int unsigned WDOG_CYCLES =
        NUM_TESTS * (int'(hawk_pkg::DPAGE_LINES) + 2) * 20 + 200;
    localparam int unsigned CHK_W       = hawk_pkg::DATA_W + hawk_pkg::STRB_W;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  trigger;
    hawk_pkg::page_pkt_t   page_pkt;
    logic                  mig_req;
    hawk_pkg::mig_pkt_t    mig_pkt;
    logic                  awvalid;
    hawk_pkg::wr_beat_aw_t aw;
    logic                  awready;
    logic                  wvalid;
    hawk_pkg::wr_beat_w_t  w;
    logic                  wready;
    logic                  cmpdcmp_done;
    logic                  compact_done;

    logic [hawk_pkg::ADDR_W-1:0] exp_aw[$];
    logic [hawk_pkg::ADDR_W-1:0] act_aw[$];
    hawk_pkg::wr_beat_w_t        exp_w[$];
    hawk_pkg::wr_beat_w_t        act_w[$];
    int unsigned exp_cmp, exp_mig, cmp_cnt, mig_cnt;
    int unsigned test_cnt, fail_cnt, err_cnt;
    logic        test_fail;

    hawk_wr_top u_dut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .trigger      (trigger),
        .page_pkt     (page_pkt),
        .mig_req      (mig_req),
        .mig_pkt      (mig_pkt),
        .awvalid      (awvalid),
        .aw           (aw),
        .awready      (awready),
        .wvalid       (wvalid),
        .w            (w),
        .wready       (wready),
        .cmpdcmp_done (cmpdcmp_done),
        .compact_done (compact_done)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // every accepted beat and every done cycle is seen at the edge that completes it
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (awvalid && awready) act_aw.push_back(aw.addr);
            if (wvalid && wready) act_w.push_back(w);
            if (cmpdcmp_done) cmp_cnt++;
            if (compact_done) mig_cnt++;
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk_i);
        $display("timeout: the tests did not finish within %0d clock cycles", WDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    task automatic check_val(input string name, input logic [CHK_W-1:0] exp_v,
                             input logic [CHK_W-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("** Error %s: expected %0h, actual %0h", name, exp_v, act_v);
            test_fail = 1'b1;
            err_cnt++;
        end
    endtask

    // failed bound assertions so far, over both checker instances
    function automatic int unsigned assert_fails();
        return u_dut.u_chan_reg.u_chan_sva.err_cnt + u_dut.u_mngr.u_mngr_sva.err_cnt;
    endfunction

    task automatic drive_ready();
        forever begin
            @(posedge clk_i);
            awready <= ($urandom % 10) < 6;     // about 60 percent accept rate
            wready  <= ($urandom % 10) < 6;
        end
    endtask

    function automatic logic [hawk_pkg::PTR_W-1:0] rand_ptr();
        return {16'($urandom), 32'($urandom)};
    endfunction

    function automatic hawk_pkg::page_pkt_t make_page(input logic comp);
        hawk_pkg::page_pkt_t p;
        p.comp_decomp      = comp;
        p.cpage_byte_start = {32'($urandom), 32'($urandom)};
        p.iway_ptr         = rand_ptr();
        p.nxtway_ptr       = rand_ptr();
        p.zspg_md          = '0;
        for (int i = 0; i < 13; i++) p.zspg_md = {p.zspg_md[hawk_pkg::MD_W-33:0], $urandom};
        return p;
    endfunction

    function automatic hawk_pkg::mig_pkt_t make_mig(input logic migrate, input logic upd);
        hawk_pkg::mig_pkt_t m;
        m.migrate       = migrate;
        m.zspg_update   = upd;
        m.src_cpage_ptr = rand_ptr();
        m.dst_cpage_ptr = rand_ptr();
        m.md            = '0;
        for (int i = 0; i < 13; i++) m.md = {m.md[hawk_pkg::MD_W-33:0], $urandom};
        return m;
    endfunction

    // expected beats and done pulses, from the address, fill and metadata rules
    task automatic build_expected(input logic trig, input hawk_pkg::page_pkt_t p,
                                  input logic mig, input hawk_pkg::mig_pkt_t m);
        int unsigned                 n_lines;
        logic                        md_line;
        logic [15:0]                 fill;
        logic [hawk_pkg::ADDR_W-1:0] base;
        logic [hawk_pkg::ADDR_W-1:0] md_addr;
        hawk_pkg::wr_beat_w_t        beat;
        exp_aw.delete();
        exp_w.delete();
        exp_cmp = 0;
        exp_mig = 0;
        n_lines = 0;
        md_line = 1'b0;
        fill    = '0;
        base    = '0;
        md_addr = '0;
        beat    = '0;
        if (trig) begin                     // trigger wins over a mig_req in the same cycle
            base       = p.cpage_byte_start;
            n_lines    = p.comp_decomp ? 17 : 64;
            fill       = p.comp_decomp ? 16'h1234 : 16'hF0F0;
            md_line    = 1'b1;
            md_addr    = {16'h0, p.iway_ptr};
            beat.data  = {16'h0, p.zspg_md, p.nxtway_ptr, p.iway_ptr};
            exp_cmp    = 1;
        end else if (mig && (m.migrate || m.zspg_update)) begin
            base       = {16'h0, m.dst_cpage_ptr};
            n_lines    = m.migrate ? 17 : 0;
            fill       = 16'h5A5A;
            md_line    = !m.migrate;
            md_addr    = base;
            beat.data  = {16'h0, m.md, m.src_cpage_ptr, m.dst_cpage_ptr};
            exp_mig    = 1;
        end
        beat.strb = {2'b00, {62{1'b1}}};
        for (int k = 0; k < n_lines; k++) begin
            exp_aw.push_back(base + 64 * k);
            exp_w.push_back({{32{fill}}, {64{1'b1}}});
        end
        if (md_line) begin
            exp_aw.push_back(md_addr);
            exp_w.push_back(beat);
        end
    endtask

    task automatic send_cmd(input logic trig, input hawk_pkg::page_pkt_t p,
                            input logic mig, input hawk_pkg::mig_pkt_t m);
        @(posedge clk_i);
        trigger  <= trig;
        page_pkt <= p;
        mig_req  <= mig;
        mig_pkt  <= m;
        @(posedge clk_i);
        trigger <= 1'b0;
        mig_req <= 1'b0;
    endtask

    task automatic run_test(input string name, input logic trig, input hawk_pkg::page_pkt_t p,
                            input logic mig, input hawk_pkg::mig_pkt_t m);
        int unsigned n;
        int unsigned fails_before;
        test_fail    = 1'b0;
        fails_before = assert_fails();
        build_expected(trig, p, mig, m);
        act_aw.delete();
        act_w.delete();
        cmp_cnt = 0;
        mig_cnt = 0;
        send_cmd(trig, p, mig, m);
        if (exp_cmp + exp_mig != 0) begin
            while (cmp_cnt + mig_cnt == 0) @(posedge clk_i);
        end else begin
            repeat (200) @(posedge clk_i);      // nothing may come out in this window
        end
        repeat (2) @(posedge clk_i);
        check_val({name, " aw count"}, exp_aw.size(), act_aw.size());
        check_val({name, " w count"}, exp_w.size(), act_w.size());
        check_val({name, " aw vs w count"}, act_aw.size(), act_w.size());
        n = (act_aw.size() < exp_aw.size()) ? act_aw.size() : exp_aw.size();
        for (int i = 0; i < n; i++) begin
            check_val($sformatf("%s aw[%0d]", name, i), exp_aw[i], act_aw[i]);
        end
        n = (act_w.size() < exp_w.size()) ? act_w.size() : exp_w.size();
        for (int i = 0; i < n; i++) begin
            check_val($sformatf("%s w[%0d]", name, i), exp_w[i], act_w[i]);
        end
        check_val({name, " cmpdcmp_done cycles"}, exp_cmp, cmp_cnt);
        check_val({name, " compact_done cycles"}, exp_mig, mig_cnt);
        if (assert_fails() != fails_before) test_fail = 1'b1;  // a bound assertion fired
        test_cnt++;
        if (test_fail) fail_cnt++;
        $display("test %-20s %s", name, test_fail ? "FAIL" : "ok");
    endtask

    initial begin
        hawk_pkg::page_pkt_t p;
        hawk_pkg::mig_pkt_t  m;
        int unsigned         kind;
        void'($urandom(SEED));
        rst_ni   = 1'b0;
        trigger  = 1'b0;
        page_pkt = '0;
        mig_req  = 1'b0;
        mig_pkt  = '0;
        awready  = 1'b0;
        wready   = 1'b0;
        test_cnt = 0;
        fail_cnt = 0;
        err_cnt  = 0;
        fork
            drive_ready();
        join_none
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;

        run_test("compress", 1'b1, make_page(1'b1), 1'b0, '0);
        run_test("decompress", 1'b1, make_page(1'b0), 1'b0, '0);
        run_test("migrate_copy", 1'b0, '0, 1'b1, make_mig(1'b1, 1'b0));
        run_test("migrate_md", 1'b0, '0, 1'b1, make_mig(1'b0, 1'b1));
        run_test("same_cycle", 1'b1, make_page(1'b1), 1'b1, make_mig(1'b1, 1'b0));
        run_test("mig_no_flag", 1'b0, '0, 1'b1, make_mig(1'b0, 1'b0));

        for (int t = 0; t < NUM_RAND; t++) begin
            kind = $urandom % 4;
            p    = make_page(kind == 0);
            m    = make_mig(kind == 2, (kind == 3) || ($urandom % 2));
            run_test($sformatf("random_%0d", t), kind < 2, p, kind >= 2, m);
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt, assert_fails());
        if (fail_cnt == 0 && assert_fails() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hawk_pkg.sv
hawk_wr_cmd_latch.sv
hawk_cmpdcmp_wr_mngr.sv
hawk_wr_chan_reg.sv
hawk_wr_top.sv
hawk_wr_sva.sv
tb_hawk_wr.sv

// ==== Bender.yml ====
package:
  name: hawk_wr

sources:
  - hawk_pkg.sv
  - hawk_wr_cmd_latch.sv
  - hawk_cmpdcmp_wr_mngr.sv
  - hawk_wr_chan_reg.sv
  - hawk_wr_top.sv
  - target: test
    files:
      - hawk_wr_sva.sv
      - tb_hawk_wr.sv
